// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - rv_isa_pkg.sv
  - rv_core_pkg.sv
  - fetch_unit.sv
  - reg_bank.sv
  - decode_unit.sv
  - execute_unit.sv
  - rv_core_top.sv
  - target: simulation
    files:
      - rv_core_tb.sv

// ==== decode_unit.sv ====
//////////////////////////////
// decode unit
// Decodes the kept instructions, forwards operands
// and registers the issue bundle for execute.
//////////////////////////////

`timescale 1ns/1ps

module decode_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,
    input  rv_isa_pkg::instr_t      instruction_i,
    input  logic                    fetch_valid_i,
    output rv_core_pkg::reg_addr_t  rs1_o,
    output rv_core_pkg::reg_addr_t  rs2_o,
    input  rv_core_pkg::word_t      rs1_data_i,
    input  rv_core_pkg::word_t      rs2_data_i,
    input  logic                    ex_valid_i,
    input  rv_core_pkg::reg_addr_t  ex_rd_i,
    input  rv_core_pkg::word_t      ex_result_i,
    input  logic                    wb_valid_i,
    input  rv_core_pkg::reg_addr_t  wb_rd_i,
    input  rv_core_pkg::word_t      wb_data_i,
    output logic                    issue_valid_o,
    output rv_core_pkg::alu_op_e    issue_op_o,
    output rv_core_pkg::reg_addr_t  issue_rd_o,
    output rv_core_pkg::word_t      issue_a_o,
    output rv_core_pkg::word_t      issue_b_o
);

    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    logic    dec_valid;
    alu_op_e dec_op;
    logic    use_imm;
    word_t   imm;
    word_t   op_a;
    word_t   op_rs2;

    assign rs1_o = instruction_i[19:15];
    assign rs2_o = instruction_i[24:20];

    always_comb begin
        dec_valid = 1'b0;
        dec_op    = ALU_ADD;
        use_imm   = 1'b0;
        imm       = word_t'($signed(instruction_i[31:20]));
        case (opcode_e'(instruction_i[6:0]))
            OPC_OP: begin
                dec_valid = 1'b1;
                if (instruction_i[31:25] == F7_ALT && instruction_i[14:12] == F3_ADD_SUB) begin
                    dec_op = ALU_SUB;
                end else if (instruction_i[31:25] != F7_BASE) begin
                    dec_valid = 1'b0;
                end else begin
                    case (funct3_e'(instruction_i[14:12]))
                        F3_ADD_SUB: dec_op = ALU_ADD;
                        F3_SLT:     dec_op = ALU_SLT;
                        F3_SLTU:    dec_op = ALU_SLTU;
                        F3_XOR:     dec_op = ALU_XOR;
                        F3_OR:      dec_op = ALU_OR;
                        F3_AND:     dec_op = ALU_AND;
                        default:    dec_valid = 1'b0;
                    endcase
                end
            end
            // only ADDI is kept from the immediate group.
            OPC_OP_IMM: begin
                dec_valid = (instruction_i[14:12] == F3_ADD_SUB);
                use_imm   = 1'b1;
            end
            OPC_LUI: begin
                dec_valid = 1'b1;
                dec_op    = ALU_PASS;
                use_imm   = 1'b1;
                imm       = {instruction_i[31:12], 12'b0};
            end
            default: dec_valid = 1'b0;
        endcase
    end

    // execute holds the youngest producer and wins over write-back, which wins over the bank.
    function automatic word_t forward(reg_addr_t rs, word_t bank_data);
        if (rs == '0)                       return '0;
        else if (ex_valid_i && ex_rd_i == rs) return ex_result_i;
        else if (wb_valid_i && wb_rd_i == rs) return wb_data_i;
        else                                return bank_data;
    endfunction

    always_comb begin
        op_a   = forward(rs1_o, rs1_data_i);
        op_rs2 = forward(rs2_o, rs2_data_i);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid_o <= 1'b0;
        end else if (!stall_i) begin
            issue_valid_o <= dec_valid && fetch_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            issue_op_o <= dec_op;
            issue_rd_o <= instruction_i[11:7];
            issue_a_o  <= op_a;
            issue_b_o  <= use_imm ? imm : op_rs2;
        end
    end

    // a stalled edge freezes the stage, so no new issue can appear after it.
    issue_frozen_a: assert property (@(posedge clk) disable iff (reset)
        $past(stall_i) |-> !$rose(issue_valid_o));

endmodule

// ==== execute_unit.sv ====
//////////////////////////////
// execute unit
// Integer ALU and the write-back register
// that drives retirement.
//////////////////////////////

`timescale 1ns/1ps

module execute_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,
    input  logic                    issue_valid_i,
    input  rv_core_pkg::alu_op_e    issue_op_i,
    input  rv_core_pkg::reg_addr_t  issue_rd_i,
    input  rv_core_pkg::word_t      issue_a_i,
    input  rv_core_pkg::word_t      issue_b_i,
    output logic                    ex_valid_o,
    output rv_core_pkg::reg_addr_t  ex_rd_o,
    output rv_core_pkg::word_t      ex_result_o,
    output logic                    wb_valid_o,
    output rv_core_pkg::reg_addr_t  wb_rd_o,
    output rv_core_pkg::word_t      wb_data_o
);

    import rv_core_pkg::*;

    always_comb begin
        case (issue_op_i)
            ALU_ADD:  ex_result_o = issue_a_i + issue_b_i;
            ALU_SUB:  ex_result_o = issue_a_i - issue_b_i;
            ALU_AND:  ex_result_o = issue_a_i & issue_b_i;
            ALU_OR:   ex_result_o = issue_a_i | issue_b_i;
            ALU_XOR:  ex_result_o = issue_a_i ^ issue_b_i;
            ALU_SLT:  ex_result_o = word_t'($signed(issue_a_i) < $signed(issue_b_i));
            ALU_SLTU: ex_result_o = word_t'(issue_a_i < issue_b_i);
            default:  ex_result_o = issue_b_i;
        endcase
    end

    // the live result is visible to decode for forwarding.
    assign ex_valid_o = issue_valid_i;
    assign ex_rd_o    = issue_rd_i;

    // a stalled edge drops the strobe, so each instruction retires once;
    // the held issue bundle retires after the stall.
    always_ff @(posedge clk) begin
        if (reset || stall_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= issue_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            wb_rd_o   <= issue_rd_i;
            wb_data_o <= ex_result_o;
        end
    end

    no_retire_after_stall_a: assert property (@(posedge clk) disable iff (reset)
        $past(stall_i) |-> !wb_valid_o);

endmodule

// ==== fetch_unit.sv ====
//////////////////////////////
// fetch unit
// Program counter that produces sequential
// word addresses for the instruction memory.
//////////////////////////////

`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module fetch_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall_i,
    output rv_core_pkg::word_t  pc_o,
    output rv_core_pkg::word_t  fetch_pc_o,
    output logic                fetch_valid_o
);

    import rv_core_pkg::*;

    // the memory answers one cycle later, so the previous address is kept
    // next to a valid bit that marks the first real fetch.
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_o          <= `RV_RESET_PC;
            fetch_pc_o    <= `RV_RESET_PC;
            fetch_valid_o <= 1'b0;
        end else if (!stall_i) begin
            pc_o          <= pc_o + word_t'(`RV_PC_STEP);
            fetch_pc_o    <= pc_o;
            fetch_valid_o <= 1'b1;
        end
    end

    // the instruction memory is word addressed.
    pc_aligned_a: assert property (@(posedge clk) disable iff (reset)
        pc_o[1:0] == 2'b00);

endmodule

// ==== reg_bank.sv ====
//////////////////////////////
// register bank
// Integer register file with two combinational
// reads and one write port.
//////////////////////////////

`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module reg_bank (
    input  logic                    clk,
    input  logic                    reset,
    input  rv_core_pkg::reg_addr_t  rs1_i,
    input  rv_core_pkg::reg_addr_t  rs2_i,
    input  rv_core_pkg::reg_addr_t  rd_i,
    input  logic                    write_i,
    input  rv_core_pkg::word_t      data_i,
    output rv_core_pkg::word_t      rs1_data_o,
    output rv_core_pkg::word_t      rs2_data_o
);

    import rv_core_pkg::*;

    word_t regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_i && rd_i != '0) begin
            regs[rd_i] <= data_i;
        end
    end

    // register zero reads zero whatever the array holds.
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

    x0_zero_a: assert property (@(posedge clk) disable iff (reset)
        regs[0] == '0);

endmodule

// ==== rv_core.f ====
+incdir+.
rv_isa_pkg.sv
rv_core_pkg.sv
fetch_unit.sv
reg_bank.sv
decode_unit.sv
execute_unit.sv
rv_core_top.sv
rv_core_tb.sv

// ==== rv_core_cfg.svh ====
//////////////////////////////
// rv core configuration
// Widths, register count and fetch parameters
// shared by the core and its packages.
//////////////////////////////

`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// data and address width of the integer core.
`define RV_XLEN 32

`define RV_REG_COUNT 32

// first fetch address after reset, and the step between instructions.
`define RV_RESET_PC 32'h0000_0000
`define RV_PC_STEP 4

`endif

// ==== rv_core_pkg.sv ====
//////////////////////////////
// rv core package
// Pipeline data types shared by the stages.
//////////////////////////////

`include "rv_core_cfg.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          reg_addr_t;

    // operations the execute stage knows; ALU_PASS forwards operand b.
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS
    } alu_op_e;

endpackage

// ==== rv_core_tb.sv ====
//////////////////////////////
// rv core testbench
// Runs assembled programs through the core and
// checks each retirement against a reference model.
//////////////////////////////

`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_core_tb;

    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 2;
    localparam int MEM_WORDS    = 1024;
    localparam int TAIL_CYCLES  = 8;
    localparam int RANDOM_COUNT = 28;

    logic      clk;
    logic      reset;
    logic      stall_i;
    instr_t    instruction_i;
    word_t     instruction_address_o;
    logic      retire_valid_o;
    reg_addr_t retire_rd_o;
    word_t     retire_data_o;

    instr_t    imem [MEM_WORDS];
    instr_t    prog [$];
    word_t     shadow [`RV_REG_COUNT];
    instr_t    fetched_word;
    integer    seed;
    int        cycles;
    int        cycle_limit;
    int        pidx;
    int        retired;
    int        directed_count;
    int        expected_count;
    logic      stall_on;
    logic      stall_at_edge;
    reg_addr_t exp_rd;
    word_t     exp_data;

    rv_core_top UUT (
        .clk                   (clk),
        .reset                 (reset),
        .stall_i               (stall_i),
        .instruction_i         (instruction_i),
        .instruction_address_o (instruction_address_o),
        .retire_valid_o        (retire_valid_o),
        .retire_rd_o           (retire_rd_o),
        .retire_data_o         (retire_data_o)
    );

    always #20 clk = ~clk;

    function automatic instr_t op_word(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                       reg_addr_t rs1, reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t imm_word(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                        reg_addr_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic instr_t lui_word(logic [19:0] imm, reg_addr_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // the kept subset: register-register ops, ADDI and LUI.
    function automatic bit is_kept(instr_t ins);
        logic [2:0] f3;
        logic [6:0] f7;
        bit         kept;
        f3   = ins[14:12];
        f7   = ins[31:25];
        kept = 1'b0;
        case (ins[6:0])
            OPC_LUI:    kept = 1'b1;
            OPC_OP_IMM: kept = (f3 == F3_ADD_SUB);
            OPC_OP: begin
                if (f7 == F7_ALT) begin
                    kept = (f3 == F3_ADD_SUB);
                end else begin
                    kept = (f7 == F7_BASE) && f3 != 3'b001 && f3 != 3'b101;
                end
            end
            default:    kept = 1'b0;
        endcase
        return kept;
    endfunction

    function automatic int count_kept();
        int n;
        n = 0;
        foreach (prog[i]) begin
            if (is_kept(prog[i])) n++;
        end
        return n;
    endfunction

    // executes one kept instruction in program order on the shadow registers.
    // shadow[0] is never written, so reads of x0 give zero.
    function automatic void model_instruction(input instr_t ins, output reg_addr_t rd,
                                              output word_t value);
        word_t      a;
        word_t      b;
        word_t      imm_i;
        logic [2:0] f3;
        a     = shadow[ins[19:15]];
        b     = shadow[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        f3    = ins[14:12];
        rd    = ins[11:7];
        value = '0;
        if (ins[6:0] == OPC_LUI) begin
            value = {ins[31:12], 12'h000};
        end else if (ins[6:0] == OPC_OP_IMM) begin
            value = a + imm_i;
        end else if (ins[31:25] == F7_ALT) begin
            value = a - b;
        end else begin
            case (f3)
                F3_ADD_SUB: value = a + b;
                F3_SLT:     value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                F3_SLTU:    value = (a < b) ? 32'd1 : 32'd0;
                F3_XOR:     value = a ^ b;
                F3_OR:      value = a | b;
                F3_AND:     value = a & b;
                default:    value = '0;
            endcase
        end
        if (rd != '0) shadow[rd] = value;
    endfunction

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t actual,
                             input reg_addr_t expected);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got x%0d, expected x%0d", $time, name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "register mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "level mismatch on %s", name);
        end
    endtask

    task automatic build_directed();
        // every kept operation once.
        prog.push_back(imm_word(12'd100, 5'd0, F3_ADD_SUB, 5'd1));
        prog.push_back(imm_word(12'hFF9, 5'd0, F3_ADD_SUB, 5'd2));
        prog.push_back(lui_word(20'h12345, 5'd3));
        prog.push_back(op_word(F7_BASE, F3_ADD_SUB, 5'd4, 5'd1, 5'd2));
        prog.push_back(op_word(F7_ALT, F3_ADD_SUB, 5'd5, 5'd4, 5'd1));
        prog.push_back(op_word(F7_BASE, F3_AND, 5'd6, 5'd3, 5'd2));
        prog.push_back(op_word(F7_BASE, F3_OR, 5'd7, 5'd6, 5'd1));
        prog.push_back(op_word(F7_BASE, F3_XOR, 5'd8, 5'd7, 5'd3));
        prog.push_back(op_word(F7_BASE, F3_SLT, 5'd9, 5'd2, 5'd1));
        prog.push_back(op_word(F7_BASE, F3_SLTU, 5'd10, 5'd2, 5'd1));
        prog.push_back(op_word(F7_BASE, F3_SLT, 5'd11, 5'd1, 5'd2));
        prog.push_back(op_word(F7_BASE, F3_SLTU, 5'd12, 5'd1, 5'd2));
        // dependency chains at distance one and two.
        prog.push_back(imm_word(12'd1, 5'd13, F3_ADD_SUB, 5'd13));
        prog.push_back(imm_word(12'd1, 5'd13, F3_ADD_SUB, 5'd13));
        prog.push_back(op_word(F7_BASE, F3_ADD_SUB, 5'd14, 5'd13, 5'd0));
        prog.push_back(imm_word(12'd5, 5'd1, F3_ADD_SUB, 5'd15));
        prog.push_back(op_word(F7_BASE, F3_ADD_SUB, 5'd16, 5'd14, 5'd15));
        prog.push_back(op_word(F7_ALT, F3_ADD_SUB, 5'd16, 5'd16, 5'd13));
        // x0 as destination, then read back at distance one and two.
        prog.push_back(imm_word(12'd55, 5'd1, F3_ADD_SUB, 5'd0));
        prog.push_back(op_word(F7_BASE, F3_ADD_SUB, 5'd17, 5'd0, 5'd1));
        prog.push_back(op_word(F7_BASE, F3_OR, 5'd18, 5'd0, 5'd0));
        // encodings outside the subset: SLLI, BEQ, zero word, bad funct7, SLL.
        prog.push_back(imm_word(12'd3, 5'd1, 3'b001, 5'd19));
        prog.push_back(32'h0020_8463);
        prog.push_back(32'h0000_0000);
        prog.push_back(op_word(F7_ALT, F3_XOR, 5'd19, 5'd1, 5'd2));
        prog.push_back(op_word(F7_BASE, 3'b001, 5'd19, 5'd1, 5'd2));
        prog.push_back(op_word(F7_BASE, F3_ADD_SUB, 5'd20, 5'd19, 5'd1));
        // a bubble between producer and consumer must not forward.
        prog.push_back(imm_word(12'd9, 5'd0, F3_ADD_SUB, 5'd21));
        prog.push_back(imm_word(12'd1, 5'd21, 3'b001, 5'd21));
        prog.push_back(op_word(F7_BASE, F3_ADD_SUB, 5'd22, 5'd21, 5'd21));
    endtask

    task automatic build_random();
        int        kind;
        word_t     rnd;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            kind = $unsigned($random(seed)) % 10;
            rd   = reg_addr_t'($unsigned($random(seed)) % 8);
            rs1  = reg_addr_t'($unsigned($random(seed)) % 8);
            rs2  = reg_addr_t'($unsigned($random(seed)) % 8);
            rnd  = $random(seed);
            case (kind)
                0: prog.push_back(op_word(F7_BASE, F3_ADD_SUB, rd, rs1, rs2));
                1: prog.push_back(op_word(F7_ALT, F3_ADD_SUB, rd, rs1, rs2));
                2: prog.push_back(op_word(F7_BASE, F3_AND, rd, rs1, rs2));
                3: prog.push_back(op_word(F7_BASE, F3_OR, rd, rs1, rs2));
                4: prog.push_back(op_word(F7_BASE, F3_XOR, rd, rs1, rs2));
                5: prog.push_back(op_word(F7_BASE, F3_SLT, rd, rs1, rs2));
                6: prog.push_back(op_word(F7_BASE, F3_SLTU, rd, rs1, rs2));
                7: prog.push_back(imm_word(rnd[11:0], rs1, F3_ADD_SUB, rd));
                8: prog.push_back(lui_word(rnd[19:0], rd));
                // XORI lies outside the subset.
                default: prog.push_back(imm_word(rnd[11:0], rs1, F3_XOR, rd));
            endcase
        end
    endtask

    // synchronous instruction memory that holds its output while stalled.
    always @(posedge clk) begin
        if (!stall_i) begin
            fetched_word = imem[instruction_address_o[11:2]];
            #DRIVE_DELAY;
            instruction_i = fetched_word;
        end
    end

    always @(posedge clk) begin
        cycles++;
        stall_at_edge = stall_i;
        if (cycles >= cycle_limit) begin
            $display("Timeout: retirements stalled after %0d of %0d before the program finished",
                     retired, expected_count);
            $display("Simulation FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    // compare process, sampled mid-cycle when the retire port is stable.
    always @(negedge clk) begin
        if (!reset) begin
            if (stall_at_edge) check_bit("retire_valid_o", retire_valid_o, 1'b0);
            if (retire_valid_o) begin
                while (pidx < prog.size() && !is_kept(prog[pidx])) pidx++;
                if (pidx >= prog.size()) begin
                    $display("Retirement seen after the last program instruction had retired");
                    $display("Simulation FAILED");
                    $fatal(1, "extra retirement");
                end else begin
                    model_instruction(prog[pidx], exp_rd, exp_data);
                    check_reg("retire_rd_o", retire_rd_o, exp_rd);
                    check_word("retire_data_o", retire_data_o, exp_data);
                    pidx++;
                    retired++;
                end
            end
        end
    end

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        stall_i       = 1'b0;
        instruction_i = '0;
        stall_on      = 1'b0;
        stall_at_edge = 1'b0;
        seed          = 32'hb4e8666d;
        cycles        = 0;
        pidx          = 0;
        retired       = 0;
        foreach (shadow[i]) shadow[i] = '0;
        // unused words carry their index above an opcode outside the subset.
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = {word_t'(i) << 7} | 32'h0000_007F;
        end
        build_directed();
        directed_count = count_kept();
        build_random();
        expected_count = count_kept();
        cycle_limit    = 4 * prog.size() + RESET_CYCLES;
        foreach (prog[i]) imem[i] = prog[i];

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_word("instruction_address_o", instruction_address_o, `RV_RESET_PC);
        check_bit("retire_valid_o", retire_valid_o, 1'b0);
        @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        // the directed part runs without stalls, the random part with them.
        while (retired < expected_count) begin
            @(posedge clk);
            #DRIVE_DELAY;
            stall_on = (retired >= directed_count);
            stall_i  = stall_on && (($random(seed) & 3) == 0);
        end
        stall_i = 1'b0;
        repeat (TAIL_CYCLES) @(posedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== rv_core_top.sv ====
//////////////////////////////
// rv core top
// Three-stage integer pipeline with a
// retirement trace port.
//////////////////////////////

`timescale 1ns/1ps

module rv_core_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,
    input  rv_isa_pkg::instr_t      instruction_i,
    output rv_core_pkg::word_t      instruction_address_o,
    output logic                    retire_valid_o,
    output rv_core_pkg::reg_addr_t  retire_rd_o,
    output rv_core_pkg::word_t      retire_data_o
);

    import rv_core_pkg::*;

    logic      fetch_valid;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      issue_valid;
    alu_op_e   issue_op;
    reg_addr_t issue_rd;
    word_t     issue_a;
    word_t     issue_b;
    logic      ex_valid;
    reg_addr_t ex_rd;
    word_t     ex_result;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;

    // decode pairs instruction_i with the valid bit alone and needs no fetch address.
    fetch_unit u_fetch (
        .clk           (clk),
        .reset         (reset),
        .stall_i       (stall_i),
        .pc_o          (instruction_address_o),
        .fetch_pc_o    (),
        .fetch_valid_o (fetch_valid)
    );

    reg_bank u_reg_bank (
        .clk        (clk),
        .reset      (reset),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rd_i       (wb_rd),
        .write_i    (wb_valid),
        .data_i     (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    decode_unit u_decode (
        .clk           (clk),
        .reset         (reset),
        .stall_i       (stall_i),
        .instruction_i (instruction_i),
        .fetch_valid_i (fetch_valid),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .ex_valid_i    (ex_valid),
        .ex_rd_i       (ex_rd),
        .ex_result_i   (ex_result),
        .wb_valid_i    (wb_valid),
        .wb_rd_i       (wb_rd),
        .wb_data_i     (wb_data),
        .issue_valid_o (issue_valid),
        .issue_op_o    (issue_op),
        .issue_rd_o    (issue_rd),
        .issue_a_o     (issue_a),
        .issue_b_o     (issue_b)
    );

    execute_unit u_execute (
        .clk           (clk),
        .reset         (reset),
        .stall_i       (stall_i),
        .issue_valid_i (issue_valid),
        .issue_op_i    (issue_op),
        .issue_rd_i    (issue_rd),
        .issue_a_i     (issue_a),
        .issue_b_i     (issue_b),
        .ex_valid_o    (ex_valid),
        .ex_rd_o       (ex_rd),
        .ex_result_o   (ex_result),
        .wb_valid_o    (wb_valid),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data)
    );

    // the write-back port is also the retirement trace.
    assign retire_valid_o = wb_valid;
    assign retire_rd_o    = wb_rd;
    assign retire_data_o  = wb_data;

endmodule

// ==== rv_isa_pkg.sv ====
//////////////////////////////
// rv isa package
// Instruction word and the encoding fields
// of the kept integer subset.
//////////////////////////////

package rv_isa_pkg;

    typedef logic [31:0] instr_t;

    // major opcodes that decode accepts, everything else is a bubble.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    // funct7 values of the register-register group.
    // the alternate value selects subtraction.
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage
